// ==== include/ttc_defs.svh ====
// Timer counter register map
`ifndef TTC_DEFS_SVH
`define TTC_DEFS_SVH

`define TTC_NUM_TIMERS      3        // Timers and interrupt lines

// ---------------------------------------------------------------------
// Register bases, timer i adds 4*(i-1)
// ---------------------------------------------------------------------
`define TTC_CLK_CTRL_BASE   8'h00
`define TTC_CNTR_CTRL_BASE  8'h0C
`define TTC_CNT_VAL_BASE    8'h18    // Read only
`define TTC_INTERVAL_BASE   8'h24
`define TTC_MATCH1_BASE     8'h30
`define TTC_MATCH2_BASE     8'h3C
`define TTC_MATCH3_BASE     8'h48
`define TTC_INTR_BASE       8'h54    // Clear on read
`define TTC_INTR_EN_BASE    8'h60

`define TTC_CNTR_CTRL_RST   5'h01    // Timer disabled out of reset

// Field widths
`define TTC_CNT_W           16
`define TTC_CLK_CTRL_W      5
`define TTC_CNTR_CTRL_W     5
`define TTC_INTR_W          5

// Clock control fields
`define TTC_CLK_EN          0        // Prescaler enable
`define TTC_CLK_N_LSB       1
`define TTC_CLK_N_MSB       4

// Counter control fields
`define TTC_CTRL_DIS        0
`define TTC_CTRL_INTV       1
`define TTC_CTRL_DOWN       2
`define TTC_CTRL_MATCH      3
`define TTC_CTRL_RST        4        // Self clearing

// Interrupt bits, match k sits at bit k
`define TTC_INTR_INTV       0
`define TTC_INTR_OVF        4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the timer counter testbench with Verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f ttc_lite.f \
   --top-module ttc_lite_tb --Mdir obj_dir -o ttc_lite_sim > build.log 2>&1 \
   && ./obj_dir/ttc_lite_sim > sim.log 2>&1 \
   || echo "Build or run failed, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
   && echo "Result: pass" \
   || { echo "Result: fail"; exit 1; }
exit 0

// ==== ttc_lite.f ====
+incdir+include
verilog/ttc_pkg.sv
verilog/ttc_prescaler.sv
verilog/ttc_timer_counter.sv
verilog/ttc_apb_regs.sv
verilog/ttc_lite.sv
verif/ttc_lite_tb.sv

// ==== verif/ttc_lite_tb.sv ====
// Timer counter testbench
`timescale 1ns/1ps
`include "ttc_defs.svh"

module ttc_lite_tb;

   typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE} op_e;

   // One table row, data is the cycle count for idle rows
   typedef struct packed {
      op_e         op;
      logic [7:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;       // Expected prdata on reads
      logic        irq_chk;   // Check interrupt after the row
      logic [3:1]  irq_exp;
   } row_t;

   logic                     pclk;
   logic                     arst_n;
   logic                     psel;
   logic                     penable;
   logic                     pwrite;
   ttc_pkg::apb_addr_t       paddr;
   ttc_pkg::apb_data_t       pwdata;
   ttc_pkg::apb_data_t       prdata;
   logic [`TTC_NUM_TIMERS:1] interrupt;

   row_t        rows[$];
   int          err_cnt;
   int          chk_cnt;
   int          cycle_cnt;
   int          cycle_limit;     // Table length plus margin
   logic        table_ready;
   logic [31:0] lfsr_state;

   localparam logic [7:0] all_bases [0:8] = '{
      `TTC_CLK_CTRL_BASE, `TTC_CNTR_CTRL_BASE, `TTC_CNT_VAL_BASE,
      `TTC_INTERVAL_BASE, `TTC_MATCH1_BASE, `TTC_MATCH2_BASE,
      `TTC_MATCH3_BASE, `TTC_INTR_BASE, `TTC_INTR_EN_BASE};

   ttc_lite UUT (
      .pclk     (pclk),
      .arst_n   (arst_n),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .interrupt(interrupt)
   );

   initial begin
      pclk = 1'b0;
      forever #10 pclk = ~pclk;   // 20 ns period
   end

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int k = 0; k < n; k++) begin
         fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         val        = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [7:0] reg_addr(input logic [7:0] base, input int t);
      return base + 8'((t - 1) * 4);   // Timers 4 bytes apart
   endfunction

   // Implemented bits of each register
   function automatic logic [31:0] field_mask(input logic [7:0] base);
      case (base)
         `TTC_CLK_CTRL_BASE:  return 32'h1F;
         `TTC_CNTR_CTRL_BASE: return 32'h0F;   // Reset bit reads 0
         `TTC_INTR_EN_BASE:   return 32'h1F;
         default:             return 32'hFFFF;
      endcase
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERROR %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      end
   endtask

   // ---------------------------------------------------------------------
   // Table building
   // ---------------------------------------------------------------------
   task automatic push_write(input logic [7:0] addr, input logic [31:0] data);
      rows.push_back(row_t'{OP_WR, addr, data, 32'h0, 1'b0, 3'b000});
      cycle_limit += 4;
   endtask

   task automatic push_read(input logic [7:0] addr, input logic [31:0] exp,
                            input logic irq_chk = 1'b0, input logic [3:1] irq_exp = 3'b000);
      rows.push_back(row_t'{OP_RD, addr, 32'h0, exp, irq_chk, irq_exp});
      cycle_limit += 4;
   endtask

   task automatic push_idle(input int n, input logic [3:1] irq_exp);
      rows.push_back(row_t'{OP_IDLE, 8'h00, 32'(n), 32'h0, 1'b1, irq_exp});
      cycle_limit += n + 1;
   endtask

   task automatic build_table();
      logic [7:0]  base;
      logic [31:0] wdata;
      for (int t = 1; t <= 3; t++) begin   // Reset values
         for (int b = 0; b < 9; b++) begin
            base = all_bases[b];
            push_read(reg_addr(base, t), (base == `TTC_CNTR_CTRL_BASE) ?
                      32'(`TTC_CNTR_CTRL_RST) : 32'h0, 1'b1, 3'b000);
         end
      end
      for (int t = 1; t <= 3; t++) begin   // Random readback
         for (int b = 0; b < 9; b++) begin
            base = all_bases[b];
            if (base != `TTC_CNT_VAL_BASE && base != `TTC_INTR_BASE) begin
               wdata = take_bits(32);
               if (base == `TTC_CNTR_CTRL_BASE)
                  wdata[`TTC_CTRL_DIS] = 1'b1;   // Counter stays held
               push_write(reg_addr(base, t), wdata);
               push_read(reg_addr(base, t), wdata & field_mask(base));
            end
         end
      end
      for (int t = 1; t <= 3; t++) begin   // Back to known zeros
         for (int b = 0; b < 9; b++) begin
            base = all_bases[b];
            if (base != `TTC_CNT_VAL_BASE && base != `TTC_INTR_BASE &&
                base != `TTC_CNTR_CTRL_BASE)
               push_write(reg_addr(base, t), 32'h0);
         end
         push_write(reg_addr(`TTC_CNTR_CTRL_BASE, t), 32'h11);   // Held, count cleared
         push_read(reg_addr(`TTC_CNTR_CTRL_BASE, t), 32'h01);
         push_read(reg_addr(`TTC_CNT_VAL_BASE, t), 32'h0);
         push_read(reg_addr(`TTC_INTR_BASE, t), 32'h0, 1'b1, 3'b000);
      end
      // Timer 1 up count, interval 20
      push_write(reg_addr(`TTC_INTERVAL_BASE, 1), 32'd20);
      push_write(reg_addr(`TTC_INTR_EN_BASE, 1), 32'h01);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 1), 32'h02);   // Run, interval mode
      push_idle(60, 3'b001);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 1), 32'h03);
      push_read(reg_addr(`TTC_INTR_BASE, 1), 32'h01, 1'b1, 3'b000);
      push_read(reg_addr(`TTC_INTR_BASE, 1), 32'h00);          // Cleared by first read
      // Timer 2 match 2 at 10
      push_write(reg_addr(`TTC_MATCH1_BASE, 2), 32'h8000);    // Out of reach
      push_write(reg_addr(`TTC_MATCH2_BASE, 2), 32'd10);
      push_write(reg_addr(`TTC_MATCH3_BASE, 2), 32'h8000);
      push_write(reg_addr(`TTC_INTR_EN_BASE, 2), 32'h1F);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 2), 32'h08);   // Run, match on
      push_idle(40, 3'b010);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 2), 32'h09);
      push_read(reg_addr(`TTC_INTR_BASE, 2), 32'h04, 1'b1, 3'b000);
      push_read(reg_addr(`TTC_INTR_BASE, 1), 32'h00);
      push_read(reg_addr(`TTC_INTR_BASE, 3), 32'h00);
      // Timer 3 down count with counter reset
      push_write(reg_addr(`TTC_INTERVAL_BASE, 3), 32'd30);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 3), 32'h17);   // Held, down, reload
      push_read(reg_addr(`TTC_CNTR_CTRL_BASE, 3), 32'h07);
      push_read(reg_addr(`TTC_CNT_VAL_BASE, 3), 32'd30);
      push_write(reg_addr(`TTC_INTR_EN_BASE, 3), 32'h01);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 3), 32'h06);
      push_idle(60, 3'b100);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 3), 32'h07);
      push_read(reg_addr(`TTC_INTR_BASE, 3), 32'h01, 1'b1, 3'b000);
      // Timer 1 prescaler N=3, tick every 16 cycles
      push_write(reg_addr(`TTC_CLK_CTRL_BASE, 1), 32'h07);
      push_write(reg_addr(`TTC_MATCH1_BASE, 1), 32'd8);
      push_write(reg_addr(`TTC_MATCH2_BASE, 1), 32'h8000);
      push_write(reg_addr(`TTC_MATCH3_BASE, 1), 32'h8000);
      push_write(reg_addr(`TTC_INTR_EN_BASE, 1), 32'h02);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 1), 32'h11);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 1), 32'h08);
      push_idle(40, 3'b000);                                   // Three ticks at most
      push_read(reg_addr(`TTC_INTR_BASE, 1), 32'h00);
      push_idle(200, 3'b001);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 1), 32'h09);
      push_read(reg_addr(`TTC_INTR_BASE, 1), 32'h02, 1'b1, 3'b000);
      push_write(reg_addr(`TTC_CLK_CTRL_BASE, 1), 32'h00);
      // Timer 2 free running overflow from 0xFFF0
      push_write(reg_addr(`TTC_INTERVAL_BASE, 2), 32'hFFF0);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 2), 32'h17);
      push_read(reg_addr(`TTC_CNT_VAL_BASE, 2), 32'hFFF0);
      push_write(reg_addr(`TTC_INTR_EN_BASE, 2), 32'h10);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 2), 32'h00);   // Up, no interval
      push_idle(40, 3'b010);
      push_write(reg_addr(`TTC_CNTR_CTRL_BASE, 2), 32'h01);
      push_read(reg_addr(`TTC_INTR_BASE, 2), 32'h10, 1'b1, 3'b000);
   endtask

   // ---------------------------------------------------------------------
   // APB transfers, no wait states
   // ---------------------------------------------------------------------
   task automatic apb_write(input ttc_pkg::apb_addr_t addr, input ttc_pkg::apb_data_t data);
      @(posedge pclk);
      psel    <= 1'b1;   // Setup
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge pclk);
      penable <= 1'b1;   // Access
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic apb_read(input ttc_pkg::apb_addr_t addr, output ttc_pkg::apb_data_t data);
      @(posedge pclk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge pclk);
      penable <= 1'b1;
      @(negedge pclk);
      data = prdata;     // Mid access phase
      @(posedge pclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   initial begin
      row_t               r;
      ttc_pkg::apb_data_t rd_data;
      arst_n      = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      err_cnt     = 0;
      chk_cnt     = 0;
      lfsr_state  = 32'h8d5c;
      cycle_limit = 5 + 200;   // Reset plus margin
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge pclk);
      arst_n <= 1'b1;
      foreach (rows[i]) begin
         r = rows[i];
         case (r.op)
            OP_WR: apb_write(r.addr, r.data);
            OP_RD: begin
               apb_read(r.addr, rd_data);
               compare($sformatf("prdata[%02h]", r.addr), rd_data, r.exp);
            end
            default: repeat (r.data) @(posedge pclk);
         endcase
         if (r.irq_chk) begin
            @(negedge pclk);
            compare("interrupt", 32'(interrupt), 32'(r.irq_exp));
         end
      end
      $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial begin
      cycle_cnt = 0;
      wait (table_ready === 1'b1);
      while (cycle_cnt < cycle_limit) begin
         @(posedge pclk);
         cycle_cnt++;
      end
      err_cnt++;
      $display("Run did not complete within %0d clock cycles", cycle_limit);
      $display("Checks: %0d  Errors: %0d", chk_cnt, err_cnt);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== verilog/ttc_apb_regs.sv ====
// APB register interface
`timescale 1ns/1ps
`include "ttc_defs.svh"

module ttc_apb_regs (
   input  logic                     pclk,
   input  logic                     arst_n,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  ttc_pkg::apb_addr_t       paddr,
   // Register values from the timers
   input  ttc_pkg::clk_ctrl_t       clk_ctrl_1, clk_ctrl_2, clk_ctrl_3,
   input  ttc_pkg::cntr_ctrl_t      cntr_ctrl_1, cntr_ctrl_2, cntr_ctrl_3,
   input  ttc_pkg::cnt_t            counter_val_1, counter_val_2, counter_val_3,
   input  ttc_pkg::cnt_t            interval_1, interval_2, interval_3,
   input  ttc_pkg::cnt_t            match_1_1, match_1_2, match_1_3,
   input  ttc_pkg::cnt_t            match_2_1, match_2_2, match_2_3,
   input  ttc_pkg::cnt_t            match_3_1, match_3_2, match_3_3,
   input  ttc_pkg::intr_t           intr_reg_1, intr_reg_2, intr_reg_3,
   input  ttc_pkg::intr_t           intr_en_1, intr_en_2, intr_en_3,
   output ttc_pkg::apb_data_t       prdata,
   // Strobes indexed by timer
   output logic [`TTC_NUM_TIMERS:1] clk_ctrl_sel,
   output logic [`TTC_NUM_TIMERS:1] cntr_ctrl_sel,
   output logic [`TTC_NUM_TIMERS:1] interval_sel,
   output logic [`TTC_NUM_TIMERS:1] match_1_sel,
   output logic [`TTC_NUM_TIMERS:1] match_2_sel,
   output logic [`TTC_NUM_TIMERS:1] match_3_sel,
   output logic [`TTC_NUM_TIMERS:1] intr_en_sel,
   output logic [`TTC_NUM_TIMERS:1] clear_intr
);

   ttc_pkg::apb_data_t rd_mux;
   logic               wr_acc;     // Write access phase
   logic               rd_acc;     // Read access phase
   logic               rd_setup;   // Read setup phase

   assign wr_acc   = psel && penable && pwrite;
   assign rd_acc   = psel && penable && !pwrite;
   assign rd_setup = psel && !penable && !pwrite;

   // ---------------------------------------------------------------------
   // Write and clear strobes
   // ---------------------------------------------------------------------
   always_comb begin
      ttc_pkg::apb_addr_t tmr_off;
      for (int i = 1; i <= `TTC_NUM_TIMERS; i++) begin
         tmr_off          = ttc_pkg::apb_addr_t'((i - 1) << 2);   // 4 bytes per timer
         clk_ctrl_sel[i]  = wr_acc && (paddr == `TTC_CLK_CTRL_BASE + tmr_off);
         cntr_ctrl_sel[i] = wr_acc && (paddr == `TTC_CNTR_CTRL_BASE + tmr_off);
         interval_sel[i]  = wr_acc && (paddr == `TTC_INTERVAL_BASE + tmr_off);
         match_1_sel[i]   = wr_acc && (paddr == `TTC_MATCH1_BASE + tmr_off);
         match_2_sel[i]   = wr_acc && (paddr == `TTC_MATCH2_BASE + tmr_off);
         match_3_sel[i]   = wr_acc && (paddr == `TTC_MATCH3_BASE + tmr_off);
         intr_en_sel[i]   = wr_acc && (paddr == `TTC_INTR_EN_BASE + tmr_off);
         clear_intr[i]    = rd_acc && (paddr == `TTC_INTR_BASE + tmr_off);
      end
   end

   // ---------------------------------------------------------------------
   // Read data mux
   // ---------------------------------------------------------------------
   always_comb begin
      rd_mux = '0;                                       // Unmapped reads 0
      case (paddr)
         `TTC_CLK_CTRL_BASE:           rd_mux = 32'(clk_ctrl_1);
         `TTC_CLK_CTRL_BASE + 8'h04:   rd_mux = 32'(clk_ctrl_2);
         `TTC_CLK_CTRL_BASE + 8'h08:   rd_mux = 32'(clk_ctrl_3);
         `TTC_CNTR_CTRL_BASE:          rd_mux = 32'(cntr_ctrl_1);
         `TTC_CNTR_CTRL_BASE + 8'h04:  rd_mux = 32'(cntr_ctrl_2);
         `TTC_CNTR_CTRL_BASE + 8'h08:  rd_mux = 32'(cntr_ctrl_3);
         `TTC_CNT_VAL_BASE:            rd_mux = 32'(counter_val_1);
         `TTC_CNT_VAL_BASE + 8'h04:    rd_mux = 32'(counter_val_2);
         `TTC_CNT_VAL_BASE + 8'h08:    rd_mux = 32'(counter_val_3);
         `TTC_INTERVAL_BASE:           rd_mux = 32'(interval_1);
         `TTC_INTERVAL_BASE + 8'h04:   rd_mux = 32'(interval_2);
         `TTC_INTERVAL_BASE + 8'h08:   rd_mux = 32'(interval_3);
         `TTC_MATCH1_BASE:             rd_mux = 32'(match_1_1);
         `TTC_MATCH1_BASE + 8'h04:     rd_mux = 32'(match_1_2);
         `TTC_MATCH1_BASE + 8'h08:     rd_mux = 32'(match_1_3);
         `TTC_MATCH2_BASE:             rd_mux = 32'(match_2_1);
         `TTC_MATCH2_BASE + 8'h04:     rd_mux = 32'(match_2_2);
         `TTC_MATCH2_BASE + 8'h08:     rd_mux = 32'(match_2_3);
         `TTC_MATCH3_BASE:             rd_mux = 32'(match_3_1);
         `TTC_MATCH3_BASE + 8'h04:     rd_mux = 32'(match_3_2);
         `TTC_MATCH3_BASE + 8'h08:     rd_mux = 32'(match_3_3);
         `TTC_INTR_BASE:               rd_mux = 32'(intr_reg_1);
         `TTC_INTR_BASE + 8'h04:       rd_mux = 32'(intr_reg_2);
         `TTC_INTR_BASE + 8'h08:       rd_mux = 32'(intr_reg_3);
         `TTC_INTR_EN_BASE:            rd_mux = 32'(intr_en_1);
         `TTC_INTR_EN_BASE + 8'h04:    rd_mux = 32'(intr_en_2);
         `TTC_INTR_EN_BASE + 8'h08:    rd_mux = 32'(intr_en_3);
         default:                      rd_mux = '0;
      endcase
   end

   // Sampled in setup, valid through access
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n)
         prdata <= '0;
      else if (rd_setup)
         prdata <= rd_mux;   // Interrupt value before its clear
   end

   // One register touched per access across all timers
   a_one_strobe : assert property (@(posedge pclk) disable iff (!arst_n)
      $onehot0({clk_ctrl_sel, cntr_ctrl_sel, interval_sel, match_1_sel,
                match_2_sel, match_3_sel, intr_en_sel, clear_intr}));

endmodule

// ==== verilog/ttc_lite.sv ====
// Triple timer counter top
`timescale 1ns/1ps
`include "ttc_defs.svh"

module ttc_lite (
   input  logic                     pclk,
   input  logic                     arst_n,
   input  logic                     psel,
   input  logic                     penable,
   input  logic                     pwrite,
   input  ttc_pkg::apb_addr_t       paddr,
   input  ttc_pkg::apb_data_t       pwdata,
   output ttc_pkg::apb_data_t       prdata,
   output logic [`TTC_NUM_TIMERS:1] interrupt   // One line per timer
);

   // ---------------------------------------------------------------------
   // Per timer register values
   // ---------------------------------------------------------------------
   ttc_pkg::clk_ctrl_t  clk_ctrl  [1:`TTC_NUM_TIMERS];
   ttc_pkg::cntr_ctrl_t cntr_ctrl [1:`TTC_NUM_TIMERS];
   ttc_pkg::cnt_t       cnt_val   [1:`TTC_NUM_TIMERS];   // Live count
   ttc_pkg::cnt_t       interval  [1:`TTC_NUM_TIMERS];
   ttc_pkg::cnt_t       match_1   [1:`TTC_NUM_TIMERS];
   ttc_pkg::cnt_t       match_2   [1:`TTC_NUM_TIMERS];
   ttc_pkg::cnt_t       match_3   [1:`TTC_NUM_TIMERS];
   ttc_pkg::intr_t      intr_reg  [1:`TTC_NUM_TIMERS];
   ttc_pkg::intr_t      intr_en   [1:`TTC_NUM_TIMERS];

   // Strobes, bit i for timer i
   logic [`TTC_NUM_TIMERS:1] clk_ctrl_sel;
   logic [`TTC_NUM_TIMERS:1] cntr_ctrl_sel;
   logic [`TTC_NUM_TIMERS:1] interval_sel;
   logic [`TTC_NUM_TIMERS:1] match_1_sel;
   logic [`TTC_NUM_TIMERS:1] match_2_sel;
   logic [`TTC_NUM_TIMERS:1] match_3_sel;
   logic [`TTC_NUM_TIMERS:1] intr_en_sel;
   logic [`TTC_NUM_TIMERS:1] clear_intr;

   ttc_apb_regs u_apb_regs (
      .pclk(pclk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
      .paddr(paddr),
      .clk_ctrl_1 (clk_ctrl[1]),  .clk_ctrl_2 (clk_ctrl[2]),  .clk_ctrl_3 (clk_ctrl[3]),
      .cntr_ctrl_1(cntr_ctrl[1]), .cntr_ctrl_2(cntr_ctrl[2]), .cntr_ctrl_3(cntr_ctrl[3]),
      .counter_val_1(cnt_val[1]), .counter_val_2(cnt_val[2]), .counter_val_3(cnt_val[3]),
      .interval_1 (interval[1]),  .interval_2 (interval[2]),  .interval_3 (interval[3]),
      .match_1_1  (match_1[1]),   .match_1_2  (match_1[2]),   .match_1_3  (match_1[3]),
      .match_2_1  (match_2[1]),   .match_2_2  (match_2[2]),   .match_2_3  (match_2[3]),
      .match_3_1  (match_3[1]),   .match_3_2  (match_3[2]),   .match_3_3  (match_3[3]),
      .intr_reg_1 (intr_reg[1]),  .intr_reg_2 (intr_reg[2]),  .intr_reg_3 (intr_reg[3]),
      .intr_en_1  (intr_en[1]),   .intr_en_2  (intr_en[2]),   .intr_en_3  (intr_en[3]),
      .prdata       (prdata),
      .clk_ctrl_sel (clk_ctrl_sel),
      .cntr_ctrl_sel(cntr_ctrl_sel),
      .interval_sel (interval_sel),
      .match_1_sel  (match_1_sel),
      .match_2_sel  (match_2_sel),
      .match_3_sel  (match_3_sel),
      .intr_en_sel  (intr_en_sel),
      .clear_intr   (clear_intr)
   );

   // ---------------------------------------------------------------------
   // Three identical timers
   // ---------------------------------------------------------------------
   for (genvar i = 1; i <= `TTC_NUM_TIMERS; i++) begin : g_timer
      ttc_timer_counter u_timer (
         .pclk         (pclk),
         .arst_n       (arst_n),
         .pwdata       (pwdata[15:0]),      // Registers are 16 bits at most
         .clk_ctrl_sel (clk_ctrl_sel[i]),
         .cntr_ctrl_sel(cntr_ctrl_sel[i]),
         .interval_sel (interval_sel[i]),
         .match_sel    ({match_3_sel[i], match_2_sel[i], match_1_sel[i]}),
         .intr_en_sel  (intr_en_sel[i]),
         .clear_intr   (clear_intr[i]),
         .clk_ctrl     (clk_ctrl[i]),
         .cntr_ctrl    (cntr_ctrl[i]),
         .counter_val  (cnt_val[i]),
         .interval     (interval[i]),
         .match_1      (match_1[i]),
         .match_2      (match_2[i]),
         .match_3      (match_3[i]),
         .intr_reg     (intr_reg[i]),
         .intr_en      (intr_en[i]),
         .interrupt    (interrupt[i])
      );
   end

endmodule

// ==== verilog/ttc_pkg.sv ====
// Timer counter types
`include "ttc_defs.svh"

package ttc_pkg;

   typedef logic [7:0]                    apb_addr_t;   // Byte address
   typedef logic [31:0]                   apb_data_t;

   typedef logic [`TTC_CNT_W-1:0]         cnt_t;        // Count, interval, match
   typedef logic [`TTC_CLK_CTRL_W-1:0]    clk_ctrl_t;   // {N, enable}
   typedef logic [`TTC_CNTR_CTRL_W-1:0]   cntr_ctrl_t;
   typedef logic [`TTC_INTR_W-1:0]        intr_t;       // {ovf, m3, m2, m1, intv}

   // Counting or held
   typedef enum logic {
      CNT_IDLE,
      CNT_RUN
   } cnt_state_e;

endpackage

// ==== verilog/ttc_prescaler.sv ====
// Count tick prescaler
`timescale 1ns/1ps
`include "ttc_defs.svh"

module ttc_prescaler (
   input  logic               pclk,
   input  logic               arst_n,
   input  ttc_pkg::clk_ctrl_t clk_ctrl,
   input  logic               restart,   // Clock control written
   output logic               tick
);

   logic [`TTC_CNT_W-1:0] div_cnt;       // Free running divider
   logic [`TTC_CNT_W-1:0] div_mask;      // Low N+1 bits set
   logic [3:0]            div_n;

   assign div_n = clk_ctrl[`TTC_CLK_N_MSB:`TTC_CLK_N_LSB];

   // N=15 shifts all ones out, mask ends up 0xFFFF
   assign div_mask = ~({`TTC_CNT_W{1'b1}} << ({1'b0, div_n} + 5'd1));

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         div_cnt <= '0;
      end else if (restart) begin
         div_cnt <= '0;                  // Restart period on write
      end else begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // Bypass gives a tick every cycle
   assign tick = !clk_ctrl[`TTC_CLK_EN] || ((div_cnt & div_mask) == div_mask);

endmodule

// ==== verilog/ttc_timer_counter.sv ====
// Single timer counter
`timescale 1ns/1ps
`include "ttc_defs.svh"

module ttc_timer_counter (
   input  logic                pclk,
   input  logic                arst_n,
   input  ttc_pkg::cnt_t       pwdata,
   input  logic                clk_ctrl_sel,
   input  logic                cntr_ctrl_sel,
   input  logic                interval_sel,
   input  logic [3:1]          match_sel,
   input  logic                intr_en_sel,
   input  logic                clear_intr,     // Interrupt register read
   output ttc_pkg::clk_ctrl_t  clk_ctrl,
   output ttc_pkg::cntr_ctrl_t cntr_ctrl,
   output ttc_pkg::cnt_t       counter_val,
   output ttc_pkg::cnt_t       interval,
   output ttc_pkg::cnt_t       match_1,
   output ttc_pkg::cnt_t       match_2,
   output ttc_pkg::cnt_t       match_3,
   output ttc_pkg::intr_t      intr_reg,
   output ttc_pkg::intr_t      intr_en,
   output logic                interrupt
);

   ttc_pkg::cnt_state_e cnt_state;
   ttc_pkg::cnt_t       cnt_next;
   ttc_pkg::intr_t      intr_evt;       // Events this cycle
   logic                tick;
   logic                step;           // Tick while running
   logic                cnt_rst;        // Counter reset write

   ttc_prescaler u_prescaler (
      .pclk    (pclk),
      .arst_n  (arst_n),
      .clk_ctrl(clk_ctrl),
      .restart (clk_ctrl_sel),
      .tick    (tick)
   );

   assign cnt_state = cntr_ctrl[`TTC_CTRL_DIS] ? ttc_pkg::CNT_IDLE : ttc_pkg::CNT_RUN;
   assign step      = tick && (cnt_state == ttc_pkg::CNT_RUN);
   assign cnt_rst   = cntr_ctrl_sel && pwdata[`TTC_CTRL_RST];

   // ---------------------------------------------------------------------
   // Software registers
   // ---------------------------------------------------------------------
   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         clk_ctrl  <= '0;
         cntr_ctrl <= `TTC_CNTR_CTRL_RST;
         interval  <= '0;
         match_1   <= '0;
         match_2   <= '0;
         match_3   <= '0;
         intr_en   <= '0;
      end else begin
         if (clk_ctrl_sel)
            clk_ctrl <= pwdata[`TTC_CLK_CTRL_W-1:0];
         if (cntr_ctrl_sel) begin
            cntr_ctrl                <= pwdata[`TTC_CNTR_CTRL_W-1:0];
            cntr_ctrl[`TTC_CTRL_RST] <= 1'b0;      // Never stored
         end
         if (interval_sel)
            interval <= pwdata;
         if (match_sel[1])
            match_1 <= pwdata;
         if (match_sel[2])
            match_2 <= pwdata;
         if (match_sel[3])
            match_3 <= pwdata;
         if (intr_en_sel)
            intr_en <= pwdata[`TTC_INTR_W-1:0];
      end
   end

   // ---------------------------------------------------------------------
   // Next count and interrupt events
   // ---------------------------------------------------------------------
   always_comb begin
      cnt_next = counter_val;
      intr_evt = '0;
      if (step) begin
         if (!cntr_ctrl[`TTC_CTRL_DOWN]) begin
            if (cntr_ctrl[`TTC_CTRL_INTV] && (counter_val == interval)) begin
               cnt_next                = '0;          // Interval reached
               intr_evt[`TTC_INTR_INTV] = 1'b1;
            end else begin
               cnt_next = counter_val + 1'b1;         // Wraps at top
               if (!cntr_ctrl[`TTC_CTRL_INTV] && (counter_val == '1))
                  intr_evt[`TTC_INTR_OVF] = 1'b1;
            end
         end else if (counter_val == '0) begin
            if (cntr_ctrl[`TTC_CTRL_INTV]) begin
               cnt_next                 = interval;   // Reload
               intr_evt[`TTC_INTR_INTV] = 1'b1;
            end else begin
               cnt_next                = '1;
               intr_evt[`TTC_INTR_OVF] = 1'b1;       // Underflow
            end
         end else begin
            cnt_next = counter_val - 1'b1;
         end

         // Match compares the value before this tick
         if (cntr_ctrl[`TTC_CTRL_MATCH]) begin
            intr_evt[1] = (counter_val == match_1);
            intr_evt[2] = (counter_val == match_2);
            intr_evt[3] = (counter_val == match_3);
         end
      end
   end

   always_ff @(posedge pclk or negedge arst_n) begin
      if (!arst_n) begin
         counter_val <= '0;
         intr_reg    <= '0;
      end else begin
         if (cnt_rst)
            counter_val <= pwdata[`TTC_CTRL_DOWN] ? interval : '0;
         else
            counter_val <= cnt_next;
         // New events win over a clear
         intr_reg <= (clear_intr ? '0 : intr_reg) | intr_evt;
      end
   end

   assign interrupt = |(intr_reg & intr_en);  // Masked sticky bits

   // Disabled counter only moves on a counter reset write
   a_idle_hold : assert property (@(posedge pclk) disable iff (!arst_n)
      (cnt_state == ttc_pkg::CNT_IDLE) && !cnt_rst |=> $stable(counter_val));

   a_rst_clear : assert property (@(posedge pclk) disable iff (!arst_n)
      !cntr_ctrl[`TTC_CTRL_RST]);

endmodule
